// ==== filter_vectors.txt ====
# name sel color_a color_b split expected_a expected_b
# sel in decimal, colours in rgb565 hex, split is the first column of color_b
identity 0 1234 f0f0 4 1234 f0f0
gauss 1 7bef 0841 4 7bef 0841
sharpen 2 8410 ffff 4 8410 ffff
laplace 3 a5a5 5a5a 4 0000 0000
sobel_h 4 ffff 0000 4 0000 0000
sobel_v 5 0000 ffff 4 0000 0000
sobel_avg 6 f800 001f 4 0000 0000
magenta 7 1234 5678 4 f81f f81f
identity_split3 0 07e0 f81f 3 07e0 f81f
gauss_split5 1 ffff 4208 5 ffff 4208
sharpen_split6 2 0010 fc00 6 0010 fc00
laplace_split2 3 ffff 1f1f 2 0000 0000
sobel_h_split5 4 f81f 07e0 5 0000 0000
sobel_v_split3 5 7fff 8000 3 0000 0000
magenta_split1 7 0000 ffff 1 f81f f81f
identity_back 0 5555 aaaa 4 5555 aaaa

// ==== src.f ====
+incdir+.
vf_pkg.sv
vf_ifs.sv
pipe_delay.sv
window_builder.sv
conv_kernel.sv
filter_select.sv
filter_bank_top.sv
filter_bank_asserts.sv
tb_filter_bank.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the filter bank testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_filter_bank -f src.f -o tb_filter_bank
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_filter_bank > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
  echo "simulation log has no pass line"
  exit 1
fi
exit 0

// ==== tb_filter_bank.sv ====
`include "vf_cfg.svh"

module tb_filter_bank;

  localparam int W = `VF_IMG_WIDTH;
  localparam int LINES = 6; // lines per frame
  localparam int FRAMES = 2; // frames per test, back to back
  localparam int PERIOD = 40;
  localparam int MAX_TESTS = 32;
  localparam int FULL_WIN = 2*W + 2; // from here on every tap belongs to the current test

  logic clk_65mhz = 1'b0;
  logic sys_rst;
  logic [2:0] sel;
  logic valid_in;
  logic [15:0] pixel_in;
  logic [`VF_HCOUNT_W-1:0] hcount_in;
  logic [`VF_VCOUNT_W-1:0] vcount_in;
  logic valid_out;
  logic [15:0] pixel_out;
  logic [`VF_HCOUNT_W-1:0] hcount_out;
  logic [`VF_VCOUNT_W-1:0] vcount_out;

  logic [8*24-1:0] v_name [MAX_TESTS]; // one entry per vector line
  logic [2:0] v_sel [MAX_TESTS];
  logic [15:0] v_a [MAX_TESTS];
  logic [15:0] v_b [MAX_TESTS];
  logic [15:0] v_ea [MAX_TESTS];
  logic [15:0] v_eb [MAX_TESTS];
  int v_split [MAX_TESTS]; // first column of colour b
  int num_tests = 0;
  logic vectors_loaded = 1'b0;

  int cycle = 0; // rising edges seen
  int cur = 0; // test now running
  int in_count = 0;
  int out_count = 0;
  int test_base = 0; // out_count when the test started
  int region_checks = 0;
  int in_cycle [$]; // arrival cycle per pending input
  logic [20:0] in_pos [$]; // {hcount, vcount} of every input since reset
  logic [31:0] lfsr = 32'h2faa_23cd;

  filter_bank_top DUT (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .sel(sel),
    .valid_in(valid_in),
    .pixel_in(pixel_in),
    .hcount_in(hcount_in),
    .vcount_in(vcount_in),
    .valid_out(valid_out),
    .pixel_out(pixel_out),
    .hcount_out(hcount_out),
    .vcount_out(vcount_out)
  );

  always #(PERIOD/2) clk_65mhz = ~clk_65mhz;

  always @(posedge clk_65mhz) cycle <= cycle + 1;

  task automatic check(input int t, input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %0s %s: expected %h actual %h", v_name[t], what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "mismatch, run stopped");
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1, feedback enters at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic load_vectors();
    int fd;
    int got;
    int sel_v;
    int split;
    string line;
    logic [8*24-1:0] name;
    logic [15:0] a, b, ea, eb;
    fd = $fopen("filter_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open filter_vectors.txt");
      $display("TEST FAILED");
      $fatal(1, "vector file missing");
    end
    while (!$feof(fd)) begin
      got = $fgets(line, fd);
      if (got > 1 && line.getc(0) != "#" && num_tests < MAX_TESTS) begin // skip column notes
        got = $sscanf(line, "%s %d %h %h %d %h %h", name, sel_v, a, b, split, ea, eb);
        if (got == 7) begin
          v_name[num_tests] = name;
          v_sel[num_tests] = 3'(sel_v);
          v_a[num_tests] = a;
          v_b[num_tests] = b;
          v_split[num_tests] = split;
          v_ea[num_tests] = ea;
          v_eb[num_tests] = eb;
          num_tests++;
        end
      end
    end
    $fclose(fd);
    vectors_loaded = 1'b1;
  endtask

  task automatic drive_pixel(input logic [15:0] px, input int x, input int y);
    int gap;
    lfsr = lfsr_next(lfsr);
    gap = int'(lfsr[0]);
    lfsr = lfsr_next(lfsr);
    gap = gap + 2 * int'(lfsr[0]); // 0..3 idle cycles
    repeat (gap) begin
      @(posedge clk_65mhz);
      valid_in <= 1'b0;
    end
    @(posedge clk_65mhz);
    valid_in <= 1'b1;
    pixel_in <= px;
    hcount_in <= `VF_HCOUNT_W'(x);
    vcount_in <= `VF_VCOUNT_W'(y);
  endtask

  task automatic run_test(input int t);
    cur = t;
    sel <= v_sel[t];
    @(posedge clk_65mhz);
    test_base = out_count; // pipeline is empty here
    region_checks = 0;
    for (int f = 0; f < FRAMES; f++) begin
      for (int y = 0; y < LINES; y++) begin
        for (int x = 0; x < W; x++) begin
          drive_pixel((x < v_split[t]) ? v_a[t] : v_b[t], x, y);
        end
      end
    end
    @(posedge clk_65mhz);
    valid_in <= 1'b0;
    wait (out_count == in_count); // drain, watchdog guards this
    repeat (2) @(posedge clk_65mhz);
    check(t, "region checks done", 32'd1, 32'(region_checks > 0));
  endtask

  // sample on the falling edge, away from the rising-edge updates
  always @(negedge clk_65mhz) begin
    int rel;
    int col;
    logic [20:0] exp_pos;
    if (valid_out === 1'b1) begin
      check(cur, "input pending", 32'd1, 32'(in_cycle.size() > 0));
      check(cur, "latency", `VF_TOP_LAT, cycle - in_cycle.pop_front());
      exp_pos = (out_count >= W + 1) ? in_pos[out_count-W-1] : '0; // center tap position
      check(cur, "position", 32'(exp_pos), 32'({hcount_out, vcount_out}));
      rel = out_count - test_base;
      col = int'(hcount_out);
      if (v_sel[cur] == 3'd7) begin
        check(cur, "test colour", 32'(v_ea[cur]), 32'(pixel_out));
        region_checks++;
      end else if (rel >= FULL_WIN && col >= 1 && col <= W - 2) begin // no wrapped columns
        if (col + 1 < v_split[cur]) begin
          check(cur, "region a", 32'(v_ea[cur]), 32'(pixel_out));
          region_checks++;
        end else if (col - 1 >= v_split[cur]) begin
          check(cur, "region b", 32'(v_eb[cur]), 32'(pixel_out));
          region_checks++;
        end
      end
      out_count++;
    end
    if (valid_in === 1'b1 && sys_rst === 1'b0) begin
      in_cycle.push_back(cycle);
      in_pos.push_back({hcount_in, vcount_in});
      in_count++;
    end
  end

  initial begin
    longint limit;
    wait (vectors_loaded);
    // worst case 4 cycles per pixel, margin covers reset and drains
    limit = longint'(num_tests) * FRAMES * W * LINES * 4 * PERIOD + 600 * PERIOD;
    #(limit);
    $display("watchdog expired before all tests finished, outputs went missing");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    sys_rst <= 1'b1;
    sel <= 3'd0;
    valid_in <= 1'b0;
    pixel_in <= 16'h0000;
    hcount_in <= '0;
    vcount_in <= '0;
    load_vectors();
    check(0, "vector lines", 32'd1, 32'(num_tests > 0));
    repeat (5) @(posedge clk_65mhz);
    sys_rst <= 1'b0;
    @(posedge clk_65mhz);
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== filter_bank_asserts.sv ====
`include "vf_cfg.svh"

module filter_bank_asserts (
  input logic clk_65mhz,
  input logic sys_rst,
  input logic [2:0] sel,
  input logic valid_in,
  input logic valid_out,
  input logic [15:0] pixel_out
);

  // fixed pipeline depth, one output per input
  a_latency: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    valid_out == $past(valid_in, `VF_TOP_LAT))
    else $error("valid_out does not follow valid_in by the top latency");

  // pipeline is still empty for four edges after reset
  a_rst_quiet: assert property (@(posedge clk_65mhz)
    ($past(sys_rst) || $past(sys_rst, 2) || $past(sys_rst, 3) || $past(sys_rst, 4))
      |-> !valid_out)
    else $error("valid_out high during or just after reset");

  // sel is registered with the pixel, so look one edge back
  a_magenta: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    (valid_out && $past(sel) == 3'(vf_pkg::SEL_TEST_MAGENTA))
      |-> pixel_out == 16'(vf_pkg::magenta_px))
    else $error("test colour code gave a pixel other than magenta");

endmodule

bind filter_bank_top filter_bank_asserts u_asserts (
  .clk_65mhz(clk_65mhz),
  .sys_rst(sys_rst),
  .sel(sel),
  .valid_in(valid_in),
  .valid_out(valid_out),
  .pixel_out(pixel_out)
);

// ==== filter_bank_top.sv ====
`include "vf_cfg.svh"

module filter_bank_top (
  input logic clk_65mhz,
  input logic sys_rst,
  input logic [2:0] sel, // output source, see fsel_e
  input logic valid_in, // recovered pixel strobe
  input logic [15:0] pixel_in, // rgb565
  input logic [`VF_HCOUNT_W-1:0] hcount_in,
  input logic [`VF_VCOUNT_W-1:0] vcount_in,
  output logic valid_out, // valid_in delayed by VF_TOP_LAT
  output logic [15:0] pixel_out,
  output logic [`VF_HCOUNT_W-1:0] hcount_out,
  output logic [`VF_VCOUNT_W-1:0] vcount_out
);

  win_stream_if win_bus (); // builder to every kernel
  px_stream_if px_bus [`VF_NUM_KERNELS] (); // one per kernel

  window_builder u_builder (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .valid(valid_in),
    .pixel(vf_pkg::rgb565_t'(pixel_in)),
    .hcount(hcount_in),
    .vcount(vcount_in),
    .win_out(win_bus.src)
  );

  // kernel index k runs kernel_e value k
  for (genvar k = 0; k < `VF_NUM_KERNELS; k++) begin : g_kernel
    conv_kernel #(
      .K_SELECT(vf_pkg::kernel_e'(k))
    ) u_kernel (
      .clk_65mhz(clk_65mhz),
      .sys_rst(sys_rst),
      .win_in(win_bus.snk),
      .px_out(px_bus[k].src)
    );
  end

  filter_select u_select (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .sel(vf_pkg::fsel_e'(sel)),
    .px_in(px_bus),
    .valid_out(valid_out),
    .pixel_out(pixel_out),
    .hcount_out(hcount_out),
    .vcount_out(vcount_out)
  );

endmodule

// ==== filter_select.sv ====
`include "vf_cfg.svh"

module filter_select (
  input logic clk_65mhz,
  input logic sys_rst,
  input vf_pkg::fsel_e sel,
  px_stream_if.snk px_in [`VF_NUM_KERNELS],
  output logic valid_out,
  output vf_pkg::rgb565_t pixel_out,
  output logic [`VF_HCOUNT_W-1:0] hcount_out,
  output logic [`VF_VCOUNT_W-1:0] vcount_out
);

  logic k_valid [`VF_NUM_KERNELS];
  vf_pkg::rgb565_t k_pixel [`VF_NUM_KERNELS];
  vf_pkg::pos_t k_pos [`VF_NUM_KERNELS];
  vf_pkg::rgb565_t sh; // sobel_h output
  vf_pkg::rgb565_t sv; // sobel_v output
  logic [5:0] avg_r; // sums before the halving
  logic [6:0] avg_g;
  logic [5:0] avg_b;
  logic nxt_valid;
  vf_pkg::rgb565_t nxt_pixel;
  vf_pkg::pos_t nxt_pos;

  // interface array flattened into plain arrays for the mux
  for (genvar i = 0; i < `VF_NUM_KERNELS; i++) begin : g_unpack
    assign k_valid[i] = px_in[i].valid;
    assign k_pixel[i] = px_in[i].pixel;
    assign k_pos[i] = '{hcount: px_in[i].hcount, vcount: px_in[i].vcount};
  end

  assign sh = k_pixel[vf_pkg::K_SOBEL_H];
  assign sv = k_pixel[vf_pkg::K_SOBEL_V];
  assign avg_r = {1'b0, sh.r} + {1'b0, sv.r};
  assign avg_g = {1'b0, sh.g} + {1'b0, sv.g};
  assign avg_b = {1'b0, sh.b} + {1'b0, sv.b};

  always_comb begin
    // defaults serve the magenta test code
    nxt_valid = k_valid[vf_pkg::K_IDENTITY];
    nxt_pixel = vf_pkg::magenta_px;
    nxt_pos = k_pos[vf_pkg::K_IDENTITY];
    case (sel)
      vf_pkg::SEL_SOBEL_AVG: begin
        nxt_valid = k_valid[vf_pkg::K_SOBEL_H] & k_valid[vf_pkg::K_SOBEL_V];
        nxt_pixel = '{r: avg_r[5:1], g: avg_g[6:1], b: avg_b[5:1]}; // rounds down
        nxt_pos = k_pos[vf_pkg::K_SOBEL_H];
      end
      vf_pkg::SEL_TEST_MAGENTA: begin
        nxt_pixel = vf_pkg::magenta_px;
      end
      default: begin // codes 0..5, straight pass of one kernel
        nxt_valid = k_valid[sel];
        nxt_pixel = k_pixel[sel];
        nxt_pos = k_pos[sel];
      end
    endcase
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= nxt_valid;
    end
  end

  always_ff @(posedge clk_65mhz) begin
    pixel_out <= nxt_pixel;
    hcount_out <= nxt_pos.hcount;
    vcount_out <= nxt_pos.vcount;
  end

endmodule

// ==== conv_kernel.sv ====
`include "vf_cfg.svh"

module conv_kernel #(
  parameter vf_pkg::kernel_e K_SELECT = vf_pkg::K_IDENTITY
) (
  input logic clk_65mhz,
  input logic sys_rst,
  win_stream_if.snk win_in,
  px_stream_if.src px_out
);

  // gauss weights add up to 16, every other kernel to 1 or 0
  localparam int DIV_SHIFT = (K_SELECT == vf_pkg::K_GAUSS) ? 4 : 0;

  logic [8:0][5:0] ch_r; // taps widened to 6 bits
  logic [8:0][5:0] ch_g;
  logic [8:0][5:0] ch_b;
  logic signed [11:0] sum_r; // stage 1, fits +-16*63
  logic signed [11:0] sum_g;
  logic signed [11:0] sum_b;
  vf_pkg::rgb565_t px_q; // stage 2
  logic [`VF_KERNEL_LAT-1:0] vld_pipe;
  vf_pkg::pos_t pos_pipe [`VF_KERNEL_LAT];

  // weighted 3x3 sum of one channel
  function automatic logic signed [11:0] wsum(input logic [8:0][5:0] t);
    int v [9];
    int acc;
    for (int i = 0; i < 9; i++) begin
      v[i] = int'(t[i]);
    end
    case (K_SELECT)
      vf_pkg::K_GAUSS: acc = v[0] + 2*v[1] + v[2]
                           + 2*v[3] + 4*v[4] + 2*v[5]
                           + v[6] + 2*v[7] + v[8];
      vf_pkg::K_SHARPEN: acc = 5*v[4] - v[1] - v[3] - v[5] - v[7];
      vf_pkg::K_LAPLACE: acc = 8*v[4] - (v[0] + v[1] + v[2] + v[3]
                                         + v[5] + v[6] + v[7] + v[8]);
      vf_pkg::K_SOBEL_H: acc = (v[6] + 2*v[7] + v[8]) - (v[0] + 2*v[1] + v[2]); // bottom - top
      vf_pkg::K_SOBEL_V: acc = (v[2] + 2*v[5] + v[8]) - (v[0] + 2*v[3] + v[6]); // right - left
      default: acc = v[4]; // identity
    endcase
    return 12'(acc);
  endfunction

  // scale down, then pin into 0..cmax
  function automatic logic [5:0] clamp_div(input logic signed [11:0] s, input logic [5:0] cmax);
    logic signed [11:0] q;
    q = s >>> DIV_SHIFT;
    if (q < 0) begin
      return 6'd0;
    end
    if (q > $signed({6'd0, cmax})) begin
      return cmax;
    end
    return q[5:0];
  endfunction

  always_comb begin
    for (int i = 0; i < 9; i++) begin
      ch_r[i] = {1'b0, win_in.win[i].r};
      ch_g[i] = win_in.win[i].g;
      ch_b[i] = {1'b0, win_in.win[i].b};
    end
  end

  // datapath runs every cycle, vld_pipe marks the real items
  always_ff @(posedge clk_65mhz) begin
    sum_r <= wsum(ch_r); // stage 1
    sum_g <= wsum(ch_g);
    sum_b <= wsum(ch_b);
    px_q.r <= 5'(clamp_div(sum_r, 6'd31)); // stage 2
    px_q.g <= clamp_div(sum_g, 6'd63);
    px_q.b <= 5'(clamp_div(sum_b, 6'd31));
    pos_pipe[0] <= '{hcount: win_in.hcount, vcount: win_in.vcount};
    for (int i = 1; i < `VF_KERNEL_LAT; i++) begin
      pos_pipe[i] <= pos_pipe[i-1];
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[`VF_KERNEL_LAT-2:0], win_in.valid};
    end
  end

  assign px_out.valid = vld_pipe[`VF_KERNEL_LAT-1];
  assign px_out.pixel = px_q;
  assign px_out.hcount = pos_pipe[`VF_KERNEL_LAT-1].hcount;
  assign px_out.vcount = pos_pipe[`VF_KERNEL_LAT-1].vcount;

endmodule

// ==== window_builder.sv ====
`include "vf_cfg.svh"

module window_builder (
  input logic clk_65mhz,
  input logic sys_rst,
  input logic valid, // single-cycle pixel strobe
  input vf_pkg::rgb565_t pixel,
  input logic [`VF_HCOUNT_W-1:0] hcount,
  input logic [`VF_VCOUNT_W-1:0] vcount,
  win_stream_if.src win_out
);

  vf_pkg::rgb565_t lb_mid; // pixel one line back
  vf_pkg::rgb565_t lb_top; // pixel two lines back
  vf_pkg::pos_t pos_in;
  vf_pkg::pos_t pos_center; // position of the pixel now at tap 4
  vf_pkg::win3x3_t win_q; // tap registers
  vf_pkg::pos_t pos_q;
  logic valid_q;

  assign pos_in = '{hcount: hcount, vcount: vcount};

  // first line buffer, fed straight from the stream
  pipe_delay #(
    .T(vf_pkg::rgb565_t),
    .DEPTH(`VF_IMG_WIDTH)
  ) u_lb_mid (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .shift(valid),
    .din(pixel),
    .dout(lb_mid)
  );

  // second line buffer chained off the first
  pipe_delay #(
    .T(vf_pkg::rgb565_t),
    .DEPTH(`VF_IMG_WIDTH)
  ) u_lb_top (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .shift(valid),
    .din(lb_mid),
    .dout(lb_top)
  );

  // center sits one line plus one pixel behind the newest sample
  pipe_delay #(
    .T(vf_pkg::pos_t),
    .DEPTH(`VF_IMG_WIDTH + 1)
  ) u_pos_dly (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .shift(valid),
    .din(pos_in),
    .dout(pos_center)
  );

  // each row slides left by one, new column enters at col 2
  // no line-end handling, edge windows wrap in stream order
  always_ff @(posedge clk_65mhz) begin
    if (valid) begin
      for (int r = 0; r < 3; r++) begin
        win_q[r*3+0] <= win_q[r*3+1];
        win_q[r*3+1] <= win_q[r*3+2];
      end
      win_q[2] <= lb_top; // top row
      win_q[5] <= lb_mid; // middle row
      win_q[8] <= pixel; // bottom row
      pos_q <= pos_center;
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid; // 1 cycle
    end
  end

  assign win_out.valid = valid_q;
  assign win_out.win = win_q;
  assign win_out.hcount = pos_q.hcount;
  assign win_out.vcount = pos_q.vcount;

endmodule

// ==== pipe_delay.sv ====
module pipe_delay #(
  parameter type T = logic [15:0], // payload carried per stage
  parameter int DEPTH = 1 // number of shifts from din to dout
) (
  input logic clk_65mhz,
  input logic sys_rst,
  input logic shift, // advance all stages by one
  input T din,
  output T dout
);

  T stages [DEPTH];

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;
      end
    end else if (shift) begin
      stages[0] <= din; // newest entry
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  // read before the shift, so a sample leaves DEPTH shifts after it entered
  assign dout = stages[DEPTH-1];

endmodule

// ==== vf_ifs.sv ====
`include "vf_cfg.svh"

// one pixel per valid strobe, no ready
interface px_stream_if;
  logic valid;
  vf_pkg::rgb565_t pixel;
  logic [`VF_HCOUNT_W-1:0] hcount;
  logic [`VF_VCOUNT_W-1:0] vcount;

  modport src (
    output valid, pixel, hcount, vcount
  );

  modport snk (
    input valid, pixel, hcount, vcount
  );
endinterface

// one 3x3 neighborhood per valid strobe
// hcount/vcount belong to the center tap
interface win_stream_if;
  logic valid;
  vf_pkg::win3x3_t win;
  logic [`VF_HCOUNT_W-1:0] hcount;
  logic [`VF_VCOUNT_W-1:0] vcount;

  modport src (
    output valid, win, hcount, vcount
  );

  modport snk (
    input valid, win, hcount, vcount
  );
endinterface

// ==== vf_pkg.sv ====
`include "vf_cfg.svh"

package vf_pkg;

  // rgb565 pixel, red in the top bits
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  typedef struct packed {
    logic [`VF_HCOUNT_W-1:0] hcount;
    logic [`VF_VCOUNT_W-1:0] vcount;
  } pos_t;

  // row-major 3x3, index = row*3 + col, row 0 is the oldest line
  // col 0 is the oldest pixel of a row, tap 4 is the center
  typedef rgb565_t [8:0] win3x3_t;

  typedef enum logic [2:0] {
    K_IDENTITY = 3'd0,
    K_GAUSS    = 3'd1,
    K_SHARPEN  = 3'd2,
    K_LAPLACE  = 3'd3,
    K_SOBEL_H  = 3'd4,
    K_SOBEL_V  = 3'd5
  } kernel_e;

  // select codes, 0..5 line up with kernel_e
  typedef enum logic [2:0] {
    SEL_IDENTITY     = 3'd0,
    SEL_GAUSS        = 3'd1,
    SEL_SHARPEN      = 3'd2,
    SEL_LAPLACE      = 3'd3,
    SEL_SOBEL_H      = 3'd4,
    SEL_SOBEL_V      = 3'd5,
    SEL_SOBEL_AVG    = 3'd6, // mean of the two gradients
    SEL_TEST_MAGENTA = 3'd7  // flat test colour
  } fsel_e;

  localparam rgb565_t magenta_px = '{r: 5'h1f, g: 6'h00, b: 5'h1f};

endpackage

// ==== vf_cfg.svh ====
`ifndef VF_CFG_SVH
`define VF_CFG_SVH

// frame geometry, one line holds this many pixels
`define VF_IMG_WIDTH 8

`define VF_HCOUNT_W 11 // hcount bits
`define VF_VCOUNT_W 10 // vcount bits

// one kernel instance per kernel_e entry
`define VF_NUM_KERNELS 6

// cycles, valid in to valid out
`define VF_KERNEL_LAT 2 // conv_kernel alone
`define VF_TOP_LAT 4 // builder 1 + kernel 2 + select 1

`endif
